//--- logic/carrier_settings.svh
`ifndef CARRIER_SETTINGS_SVH
`define CARRIER_SETTINGS_SVH

// Board population
`define CARRIER_NUM_BAYS 5
`define CARRIER_BAY_ID_BITS 3
`define CARRIER_IO_BITS 10

// SPI link, 3 lanes by 8 beats gives a 24-bit frame
`define CARRIER_SPI_LANES 3
`define CARRIER_FRAME_BEATS 8

// Register map
`define CARRIER_REG_OUT 4'd0
`define CARRIER_REG_OE 4'd1
`define CARRIER_REG_IN 4'd2

`endif

//--- logic/carrier_pkg.sv
`include "carrier_settings.svh"

package carrier_pkg;

    // Bay index as seen on module_id
    typedef logic [`CARRIER_BAY_ID_BITS-1:0] bay_id_t;

    // One beat across all lanes
    typedef logic [`CARRIER_SPI_LANES-1:0] spi_lanes_t;

    // Full frame, beat 0 in the top bits
    typedef logic [`CARRIER_SPI_LANES*`CARRIER_FRAME_BEATS-1:0] spi_frame_t;

    typedef logic [3:0] reg_addr_t;

    typedef logic [`CARRIER_IO_BITS-1:0] bay_pins_t;

    typedef enum logic [1:0] {
        idle,
        shift,
        done
    } frame_state_t;

endpackage

//--- logic/spi_lane_if.sv
interface spi_lane_if;

    carrier_pkg::spi_lanes_t sdi;
    logic sclk;
    // Already gated by bay selection
    logic ncs;
    carrier_pkg::spi_lanes_t sdo;

    modport host (
        output sdi,
        output sclk,
        output ncs,
        input sdo
    );

    modport bay (
        input sdi,
        input sclk,
        input ncs,
        output sdo
    );

endinterface

//--- logic/bus_router.sv
`include "carrier_settings.svh"

module bus_router (
    input carrier_pkg::bay_id_t module_id,
    input logic sncs,
    input logic sclk,
    input logic sda_oe,
    input logic scl_oe,
    input carrier_pkg::spi_lanes_t sdi,
    output carrier_pkg::spi_lanes_t sdo,
    output logic sda_out,
    output logic scl_out,
    inout wire [`CARRIER_NUM_BAYS-1:0] sda,
    inout wire [`CARRIER_NUM_BAYS-1:0] scl,
    spi_lane_if.host bays [`CARRIER_NUM_BAYS]
);

    // One-hot decode, all zero for an out-of-range id
    logic [`CARRIER_NUM_BAYS-1:0] bay_sel;
    carrier_pkg::spi_lanes_t bay_sdo [`CARRIER_NUM_BAYS];

    genvar i;
    generate
        for (i = 0; i < `CARRIER_NUM_BAYS; i = i + 1) begin : gen_bay
            assign bay_sel[i] = (module_id == i);

            // SPI fan-out, only chip select is per bay
            assign bays[i].sdi = sdi;
            assign bays[i].sclk = sclk;
            assign bays[i].ncs = ~(bay_sel[i] & ~sncs);
            assign bay_sdo[i] = bays[i].sdo;

            // Open-drain, pull low or release
            assign sda[i] = (bay_sel[i] && sda_oe) ? 1'b0 : 1'bz;
            assign scl[i] = (bay_sel[i] && scl_oe) ? 1'b0 : 1'bz;
        end
    endgenerate

    // Return path to the host, idle high when nothing is selected
    always_comb begin
        sdo = '1;
        for (int b = 0; b < `CARRIER_NUM_BAYS; b++) begin
            if (bay_sel[b]) begin
                sdo = bay_sdo[b];
            end
        end
    end

    always_comb begin
        sda_out = 1'b1;
        scl_out = 1'b1;
        for (int b = 0; b < `CARRIER_NUM_BAYS; b++) begin
            if (bay_sel[b]) begin
                sda_out = sda[b];
                scl_out = scl[b];
            end
        end
    end

endmodule

//--- logic/spi_frame_slave.sv
`include "carrier_settings.svh"

module spi_frame_slave (
    input logic clk,
    input logic rst,
    spi_lane_if.bay spi,
    output carrier_pkg::spi_frame_t frame,
    output logic frame_valid,
    input carrier_pkg::bay_pins_t read_data
);

    localparam int lanes = `CARRIER_SPI_LANES;
    localparam int frame_bits = $bits(carrier_pkg::spi_frame_t);
    localparam int beat_bits = $clog2(`CARRIER_FRAME_BEATS);

    logic sclk_meta;
    logic sclk_sync;
    logic sclk_prev;
    logic ncs_meta;
    logic ncs_sync;
    carrier_pkg::spi_lanes_t sdi_meta;
    carrier_pkg::spi_lanes_t sdi_sync;
    logic sclk_rise;
    logic last_beat;

    carrier_pkg::frame_state_t state;
    logic [beat_bits-1:0] beat;
    carrier_pkg::spi_frame_t shift_in;
    carrier_pkg::spi_frame_t shift_out;

    // Two-flop synchronizers, sclk gets a third stage for edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            ncs_meta <= 1'b1;
            ncs_sync <= 1'b1;
        end else begin
            sclk_meta <= spi.sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            ncs_meta <= spi.ncs;
            ncs_sync <= ncs_meta;
        end
    end

    always_ff @(posedge clk) begin
        sdi_meta <= spi.sdi;
        sdi_sync <= sdi_meta;
    end

    assign sclk_rise = sclk_sync & ~sclk_prev;
    assign last_beat = (beat == beat_bits'(`CARRIER_FRAME_BEATS - 1));

    // Current beat joined to what was shifted in so far
    assign frame = {shift_in[frame_bits-lanes-1:0], sdi_sync};
    assign frame_valid = (state == carrier_pkg::shift) && !ncs_sync && sclk_rise && last_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= carrier_pkg::idle;
            beat <= '0;
        end else begin
            case (state)
                carrier_pkg::idle: begin
                    if (!ncs_sync) begin
                        state <= carrier_pkg::shift;
                        beat <= '0;
                    end
                end
                carrier_pkg::shift: begin
                    // Early chip select release drops the frame
                    if (ncs_sync) begin
                        state <= carrier_pkg::idle;
                    end else if (sclk_rise) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= carrier_pkg::done;
                        end
                    end
                end
                carrier_pkg::done: begin
                    state <= carrier_pkg::idle;
                end
                default: begin
                    state <= carrier_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == carrier_pkg::shift && sclk_rise) begin
            shift_in <= frame;
        end
    end

    // Read data from the register map is settled by the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_out <= '0;
        end else if (state == carrier_pkg::done) begin
            shift_out <= frame_bits'(read_data);
        end else if (state == carrier_pkg::shift && !ncs_sync && sclk_rise) begin
            shift_out <= {shift_out[frame_bits-lanes-1:0], {lanes{1'b0}}};
        end
    end

    assign spi.sdo = shift_out[frame_bits-1 -: lanes];

endmodule

//--- logic/bay_io_regs.sv
`include "carrier_settings.svh"

module bay_io_regs (
    input logic clk,
    input logic rst,
    input carrier_pkg::spi_frame_t frame,
    input logic frame_valid,
    input carrier_pkg::bay_pins_t pins_in,
    output carrier_pkg::bay_pins_t pins_out,
    output carrier_pkg::bay_pins_t pins_oe,
    output carrier_pkg::bay_pins_t read_data
);

    localparam int frame_bits = $bits(carrier_pkg::spi_frame_t);
    localparam int addr_bits = $bits(carrier_pkg::reg_addr_t);

    carrier_pkg::reg_addr_t addr;
    logic write_en;
    carrier_pkg::bay_pins_t wdata;
    carrier_pkg::bay_pins_t in_meta;
    carrier_pkg::bay_pins_t in_sync;
    carrier_pkg::bay_pins_t out_q;
    carrier_pkg::bay_pins_t oe_q;
    carrier_pkg::bay_pins_t reg_value;

    // Address on top, then the write flag, data in the low bits
    assign addr = frame[frame_bits-1 -: addr_bits];
    assign write_en = frame_valid && frame[frame_bits-addr_bits-1];
    assign wdata = frame[`CARRIER_IO_BITS-1:0];

    always_ff @(posedge clk) begin
        in_meta <= pins_in;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= '0;
            oe_q <= '0;
        end else if (write_en) begin
            case (addr)
                `CARRIER_REG_OUT: out_q <= wdata;
                `CARRIER_REG_OE: oe_q <= wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (addr)
            `CARRIER_REG_OUT: reg_value = out_q;
            `CARRIER_REG_OE: reg_value = oe_q;
            `CARRIER_REG_IN: reg_value = in_sync;
            default: reg_value = '0;
        endcase
    end

    // Captured on every complete frame, sent back in the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data <= '0;
        end else if (frame_valid) begin
            read_data <= reg_value;
        end
    end

    assign pins_out = out_q;
    assign pins_oe = oe_q;

endmodule

//--- logic/device_handler.sv
module device_handler (
    input logic clk,
    input logic rst,
    spi_lane_if.bay spi,
    input carrier_pkg::bay_pins_t pins_in,
    output carrier_pkg::bay_pins_t pins_out,
    output carrier_pkg::bay_pins_t pins_oe
);

    carrier_pkg::spi_frame_t frame;
    logic frame_valid;
    carrier_pkg::bay_pins_t read_data;

    spi_frame_slave frame_slave_i (
        .clk(clk),
        .rst(rst),
        .spi(spi),
        .frame(frame),
        .frame_valid(frame_valid),
        .read_data(read_data)
    );

    bay_io_regs io_regs_i (
        .clk(clk),
        .rst(rst),
        .frame(frame),
        .frame_valid(frame_valid),
        .pins_in(pins_in),
        .pins_out(pins_out),
        .pins_oe(pins_oe),
        .read_data(read_data)
    );

endmodule

//--- logic/carrier_fpga.sv
`include "carrier_settings.svh"

module carrier_fpga (
    input logic clk,
    input logic rst,
    // I2C from the host
    input logic sda_oe,
    input logic scl_oe,
    output logic sda_out,
    output logic scl_out,
    // SPI from the host
    input carrier_pkg::spi_lanes_t sdi,
    output carrier_pkg::spi_lanes_t sdo,
    input logic sclk,
    input logic sncs,
    input carrier_pkg::bay_id_t module_id,
    // Bay side
    inout wire [`CARRIER_NUM_BAYS-1:0] sda,
    inout wire [`CARRIER_NUM_BAYS-1:0] scl,
    inout wire [`CARRIER_NUM_BAYS*`CARRIER_IO_BITS-1:0] module_io
);

    localparam int io_bits = `CARRIER_IO_BITS;

    carrier_pkg::bay_pins_t pins_out [`CARRIER_NUM_BAYS];
    carrier_pkg::bay_pins_t pins_oe [`CARRIER_NUM_BAYS];

    spi_lane_if bay_spi [`CARRIER_NUM_BAYS] ();

    bus_router router_i (
        .module_id(module_id),
        .sncs(sncs),
        .sclk(sclk),
        .sda_oe(sda_oe),
        .scl_oe(scl_oe),
        .sdi(sdi),
        .sdo(sdo),
        .sda_out(sda_out),
        .scl_out(scl_out),
        .sda(sda),
        .scl(scl),
        .bays(bay_spi)
    );

    genvar bay, pin;
    generate
        for (bay = 0; bay < `CARRIER_NUM_BAYS; bay = bay + 1) begin : gen_bay
            device_handler handler_i (
                .clk(clk),
                .rst(rst),
                .spi(bay_spi[bay]),
                .pins_in(module_io[bay*io_bits +: io_bits]),
                .pins_out(pins_out[bay]),
                .pins_oe(pins_oe[bay])
            );

            // Pad drivers, high impedance unless enabled
            for (pin = 0; pin < io_bits; pin = pin + 1) begin : gen_pin
                assign module_io[bay*io_bits + pin] =
                    pins_oe[bay][pin] ? pins_out[bay][pin] : 1'bz;
            end
        end
    endgenerate

endmodule

//--- verification/carrier_fpga_chk.sv
`include "carrier_settings.svh"

module carrier_fpga_chk (
    input logic clk,
    input carrier_pkg::bay_id_t module_id,
    input logic [`CARRIER_NUM_BAYS-1:0] sda,
    input carrier_pkg::spi_lanes_t sdo,
    input logic [`CARRIER_NUM_BAYS-1:0] bay_ncs
);

    int failures = 0;

    // Chip select reaches one bay at most
    one_bay_selected: assert property (@(posedge clk) $onehot0(~bay_ncs))
        else begin
            failures++;
            $error("more than one bay chip select is low");
        end

    sdo_idle_out_of_range: assert property (@(posedge clk)
        (module_id >= `CARRIER_NUM_BAYS) |-> (sdo == '1))
        else begin
            failures++;
            $error("sdo not all ones for out-of-range module_id %0d", module_id);
        end

    genvar i;
    generate
        for (i = 0; i < `CARRIER_NUM_BAYS; i = i + 1) begin : gen_sda
            unselected_sda_released: assert property (@(posedge clk)
                (module_id != i) |-> (sda[i] !== 1'b0))
                else begin
                    failures++;
                    $error("bay %0d sda low while not selected", i);
                end
        end
    endgenerate

endmodule

//--- verification/carrier_fpga_tb.sv
`include "carrier_settings.svh"

module carrier_fpga_tb;

    localparam int num_bays = `CARRIER_NUM_BAYS;
    localparam int io_bits = `CARRIER_IO_BITS;
    localparam int lanes = `CARRIER_SPI_LANES;
    localparam int beats = `CARRIER_FRAME_BEATS;
    localparam int frame_bits = lanes * beats;
    localparam int timeout_cycles = 200;
    localparam int op_write = 0;
    localparam int op_read = 1;
    localparam int op_i2c = 2;
    localparam int op_pin_in = 3;
    localparam int op_pins = 4;
    localparam int op_abort = 5;

    typedef struct {
        string name;
        int op;
        int bay;
        int addr;
        carrier_pkg::bay_pins_t data;
        carrier_pkg::bay_pins_t expected;
    } test_entry_t;

    logic clk;
    logic rst;
    logic sda_oe;
    logic scl_oe;
    logic sda_out;
    logic scl_out;
    carrier_pkg::spi_lanes_t sdi;
    carrier_pkg::spi_lanes_t sdo;
    logic sclk;
    logic sncs;
    carrier_pkg::bay_id_t module_id;
    tri1 [num_bays-1:0] sda;
    tri1 [num_bays-1:0] scl;
    wire [num_bays*io_bits-1:0] module_io;

    // Bay models for scl pull-down and pin drivers
    logic [num_bays-1:0] scl_pull;
    logic [num_bays*io_bits-1:0] drv_en;
    logic [num_bays*io_bits-1:0] drv_val;

    // Register contents expected after the writes so far
    carrier_pkg::bay_pins_t model_out [num_bays];
    carrier_pkg::bay_pins_t model_oe [num_bays];
    test_entry_t tests [$];

    carrier_fpga dut_i (
        .clk(clk),
        .rst(rst),
        .sda_oe(sda_oe),
        .scl_oe(scl_oe),
        .sda_out(sda_out),
        .scl_out(scl_out),
        .sdi(sdi),
        .sdo(sdo),
        .sclk(sclk),
        .sncs(sncs),
        .module_id(module_id),
        .sda(sda),
        .scl(scl),
        .module_io(module_io)
    );

    bind bus_router carrier_fpga_chk chk_i (
        .clk(carrier_fpga_tb.clk),
        .module_id(module_id),
        .sda(sda),
        .sdo(sdo),
        .bay_ncs({bays[4].ncs, bays[3].ncs, bays[2].ncs, bays[1].ncs, bays[0].ncs})
    );

    genvar g;
    generate
        for (g = 0; g < num_bays; g = g + 1) begin : gen_scl_model
            assign scl[g] = scl_pull[g] ? 1'b0 : 1'bz;
        end
        for (g = 0; g < num_bays * io_bits; g = g + 1) begin : gen_pin_model
            assign module_io[g] = drv_en[g] ? drv_val[g] : 1'bz;
        end
    endgenerate

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %s expected %h actual %h", name, expected, actual);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic add_test(input string name, input int op, input int bay, input int addr,
                            input carrier_pkg::bay_pins_t data,
                            input carrier_pkg::bay_pins_t expected);
        tests.push_back('{name, op, bay, addr, data, expected});
    endtask

    function automatic logic [frame_bits-1:0] make_word(input int addr, input logic write,
                                                         input carrier_pkg::bay_pins_t data);
        return {carrier_pkg::reg_addr_t'(addr), write, 9'b0, data};
    endfunction

    // Host side of one frame with sdo sampled at the end of each low phase
    task automatic spi_frame(input int bay, input logic [frame_bits-1:0] word,
                             input int beats_sent, output logic [frame_bits-1:0] returned);
        returned = '0;
        @(negedge clk);
        module_id = carrier_pkg::bay_id_t'(bay);
        sncs = 1'b0;
        repeat (4) @(negedge clk);
        for (int b = 0; b < beats_sent; b++) begin
            sdi = word[frame_bits-1-lanes*b -: lanes];
            repeat (5) @(negedge clk);
            returned[frame_bits-1-lanes*b -: lanes] = sdo;
            sclk = 1'b1;
            repeat (5) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (2) @(negedge clk);
        sncs = 1'b1;
        repeat (6) @(negedge clk);
    endtask

    task automatic check_pins(input string name);
        logic [num_bays*io_bits-1:0] expected;
        int waited;
        for (int k = 0; k < num_bays * io_bits; k++) begin
            if (model_oe[k / io_bits][k % io_bits]) begin
                expected[k] = model_out[k / io_bits][k % io_bits];
            end else begin
                expected[k] = drv_en[k] ? drv_val[k] : 1'bz;
            end
        end
        waited = 0;
        while (module_io !== expected && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        assert (module_io === expected)
            else report_mismatch(name, expected, module_io);
    endtask

    task automatic check_i2c(input test_entry_t t);
        logic [num_bays-1:0] sda_expected;
        logic [num_bays-1:0] scl_expected;
        logic [1:0] seen;
        @(negedge clk);
        module_id = carrier_pkg::bay_id_t'(t.bay);
        sda_oe = t.data[0];
        scl_oe = t.data[1];
        scl_pull = '0;
        if (t.addr < num_bays) begin
            scl_pull[t.addr] = 1'b1;
        end
        @(negedge clk);
        for (int i = 0; i < num_bays; i++) begin
            sda_expected[i] = !(i == t.bay && t.data[0]);
            scl_expected[i] = !((i == t.bay && t.data[1]) || i == t.addr);
        end
        seen = {scl_out, sda_out};
        assert (seen === t.expected[1:0])
            else report_mismatch(t.name, t.expected[1:0], seen);
        assert (sda === sda_expected)
            else report_mismatch({t.name, "_sda"}, sda_expected, sda);
        assert (scl === scl_expected)
            else report_mismatch({t.name, "_scl"}, scl_expected, scl);
        if (t.bay >= num_bays) begin
            assert (sdo === {lanes{1'b1}})
                else report_mismatch({t.name, "_sdo"}, {lanes{1'b1}}, sdo);
        end
        sda_oe = 1'b0;
        scl_oe = 1'b0;
        scl_pull = '0;
    endtask

    task automatic run_test(input test_entry_t t);
        logic [frame_bits-1:0] returned;
        case (t.op)
            op_write, op_abort: begin
                spi_frame(t.bay, make_word(t.addr, 1'b1, t.data),
                          (t.op == op_abort) ? 4 : beats, returned);
                if (t.op == op_write && t.bay < num_bays && t.addr == 0) begin
                    model_out[t.bay] = t.data;
                end
                if (t.op == op_write && t.bay < num_bays && t.addr == 1) begin
                    model_oe[t.bay] = t.data;
                end
            end
            op_read: begin
                // Second frame carries what the first one latched
                spi_frame(t.bay, make_word(t.addr, 1'b0, '0), beats, returned);
                spi_frame(t.bay, make_word(t.addr, 1'b0, '0), beats, returned);
                assert (returned === frame_bits'(t.expected))
                    else report_mismatch(t.name, t.expected, returned);
            end
            op_pin_in: begin
                @(negedge clk);
                for (int p = 0; p < io_bits; p++) begin
                    drv_en[t.bay*io_bits + p] = !model_oe[t.bay][p];
                    drv_val[t.bay*io_bits + p] = t.data[p];
                end
            end
            op_i2c: check_i2c(t);
            default: check_pins(t.name);
        endcase
    endtask

    initial begin
        carrier_pkg::bay_pins_t rnd0;
        carrier_pkg::bay_pins_t rnd3;
        void'($urandom(17947));
        rst = 1'b1;
        sda_oe = 1'b0;
        scl_oe = 1'b0;
        sdi = '0;
        sclk = 1'b0;
        sncs = 1'b1;
        module_id = '0;
        scl_pull = '0;
        drv_en = '0;
        drv_val = '0;
        foreach (model_out[b]) begin
            model_out[b] = '0;
            model_oe[b] = '0;
        end
        rnd0 = carrier_pkg::bay_pins_t'($urandom);
        rnd3 = carrier_pkg::bay_pins_t'($urandom);

        add_test("reset_pins_hiz", op_pins, 0, 0, 10'h0, 10'h0);
        add_test("reset_i2c_idle", op_i2c, 0, 7, 10'h0, 10'h3);
        add_test("reset_read_out_b0", op_read, 0, 0, 10'h0, 10'h0);
        add_test("reset_read_oe_b4", op_read, 4, 1, 10'h0, 10'h0);
        add_test("reset_read_unknown_b2", op_read, 2, 9, 10'h0, 10'h0);
        add_test("b0_write_oe", op_write, 0, 1, 10'h0f3, 10'h0);
        add_test("b0_write_out", op_write, 0, 0, 10'h2a5, 10'h0);
        add_test("b0_pins_driven", op_pins, 0, 0, 10'h0, 10'h0);
        add_test("b0_read_oe", op_read, 0, 1, 10'h0, 10'h0f3);
        add_test("b1_write_out", op_write, 1, 0, 10'h2c3, 10'h0);
        add_test("b1_read_out", op_read, 1, 0, 10'h0, 10'h2c3);
        add_test("b3_pin_in", op_pin_in, 3, 0, rnd3, 10'h0);
        add_test("b3_write_in_ignored", op_write, 3, 2, 10'h155, 10'h0);
        add_test("b3_read_in", op_read, 3, 2, 10'h0, rnd3);
        add_test("b0_pin_in", op_pin_in, 0, 0, rnd0, 10'h0);
        add_test("b0_read_in", op_read, 0, 2, 10'h0, (rnd0 & ~10'h0f3) | (10'h2a5 & 10'h0f3));
        add_test("i2c_sda_b2", op_i2c, 2, 7, 10'h1, 10'h2);
        add_test("i2c_scl_b4_selected", op_i2c, 4, 4, 10'h0, 10'h1);
        add_test("i2c_scl_b4_unselected", op_i2c, 1, 4, 10'h0, 10'h3);
        add_test("i2c_scl_oe_b3", op_i2c, 3, 7, 10'h2, 10'h1);
        add_test("oor_idle", op_i2c, 6, 7, 10'h3, 10'h3);
        add_test("oor_write", op_write, 6, 0, 10'h3ff, 10'h0);
        add_test("oor_pins_unchanged", op_pins, 0, 0, 10'h0, 10'h0);
        add_test("oor_b0_out_kept", op_read, 0, 0, 10'h0, 10'h2a5);
        add_test("abort_b2_oe", op_abort, 2, 1, 10'h3ff, 10'h0);
        add_test("abort_pins_unchanged", op_pins, 0, 0, 10'h0, 10'h0);
        add_test("abort_b2_oe_kept", op_read, 2, 1, 10'h0, 10'h0);
        add_test("b2_write_oe", op_write, 2, 1, 10'h3c0, 10'h0);
        add_test("b2_write_out", op_write, 2, 0, 10'h1c0, 10'h0);
        add_test("b2_pins_driven", op_pins, 0, 0, 10'h0, 10'h0);
        add_test("b2_read_out", op_read, 2, 0, 10'h0, 10'h1c0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (tests[n]) begin
            run_test(tests[n]);
        end
        repeat (4) @(negedge clk);

        if (dut_i.router_i.chk_i.failures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", dut_i.router_i.chk_i.failures);
            $display("tests failed");
            $fatal(1, "bound assertion failure");
        end
    end

endmodule

//--- carrier_fpga.f
+incdir+logic
logic/carrier_pkg.sv
logic/spi_lane_if.sv
logic/bus_router.sv
logic/spi_frame_slave.sv
logic/bay_io_regs.sv
logic/device_handler.sv
logic/carrier_fpga.sv
verification/carrier_fpga_chk.sv
verification/carrier_fpga_tb.sv
